//--- compile.f
rtl/mmu_pkg.sv
rtl/mmu_tlb_upd_if.sv
rtl/mmu_dtlb.sv
rtl/mmu_ptw.sv
rtl/mmu_lsu_stage.sv
rtl/mmu_top.sv
tb/tb_clk_gen.sv
tb/tb_mmu.sv

//--- rtl/mmu_dtlb.sv
// fully associative data TLB, combinational lookup and refill from the page table walker
`timescale 1ns/1ps
`default_nettype none

module mmu_dtlb #(
    parameter int unsigned NR_ENTRIES = mmu_pkg::TLB_ENTRIES_DEF
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    mmu_tlb_upd_if.tlb               upd,
    input  logic [mmu_pkg::VLEN-1:0] lu_vaddr_i,
    output logic                     lu_hit_o,
    output logic [mmu_pkg::PPNW-1:0] lu_ppn_o,
    output logic                     lu_is_super_o,
    output mmu_pkg::pte_flags_t      lu_flags_o
);
    import mmu_pkg::*;

    // per entry storage
    logic [NR_ENTRIES-1:0]     valid_q;
    logic [NR_ENTRIES-1:0]     super_q;
    logic [VLEN-PAGE_OFFW-1:0] tag_q   [NR_ENTRIES];
    logic [PPNW-1:0]           ppn_q   [NR_ENTRIES];
    pte_flags_t                flags_q [NR_ENTRIES];

    // round robin replacement pointer
    logic [$clog2(NR_ENTRIES)-1:0] victim_q;

    logic [VLEN-PAGE_OFFW-1:0] lu_vpn;
    logic [NR_ENTRIES-1:0]     match;

    assign lu_vpn = lu_vaddr_i[VLEN-1:PAGE_OFFW];

    // ----------------------------------------------------------------------
    // lookup
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NR_ENTRIES; i++) begin
            // superpages only compare vpn[1]
            if (super_q[i]) begin
                match[i] = valid_q[i] && (tag_q[i][2*VPNW-1:VPNW] == lu_vpn[2*VPNW-1:VPNW]);
            end else begin
                match[i] = valid_q[i] && (tag_q[i] == lu_vpn);
            end
        end
    end

    assign lu_hit_o = |match;

    always_comb begin
        lu_ppn_o      = '0;
        lu_is_super_o = 1'b0;
        lu_flags_o    = '0;
        for (int i = 0; i < NR_ENTRIES; i++) begin
            if (match[i]) begin
                lu_is_super_o = super_q[i];
                lu_flags_o    = flags_q[i];
                // low ppn bits of a superpage come straight from vpn[0]
                if (super_q[i]) begin
                    lu_ppn_o = {ppn_q[i][PPNW-1:VPNW], lu_vpn[VPNW-1:0]};
                end else begin
                    lu_ppn_o = ppn_q[i];
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // refill and flush
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else begin
            if (flush_i) begin
                // flush wins over a refill in the same cycle
                valid_q <= '0;
            end else if (upd.valid) begin
                valid_q[victim_q] <= 1'b1;
            end
            if (upd.valid) begin
                if (victim_q == ($clog2(NR_ENTRIES))'(NR_ENTRIES - 1)) begin
                    victim_q <= '0;
                end else begin
                    victim_q <= victim_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd.valid) begin
            tag_q[victim_q]   <= upd.vpn;
            ppn_q[victim_q]   <= upd.ppn;
            super_q[victim_q] <= upd.is_super;
            flags_q[victim_q] <= upd.flags;
        end
    end

    // the walker only refills on a miss, so entries never overlap
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(match));

endmodule

`default_nettype wire

//--- rtl/mmu_lsu_stage.sv
// load/store translation register, builds the physical address and raises page faults
`timescale 1ns/1ps
`default_nettype none

module mmu_lsu_stage (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       en_translation_i,
    input  logic                       lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0]   lsu_vaddr_i,
    input  logic                       lsu_is_store_i,
    input  mmu_pkg::priv_lvl_e         priv_lvl_i,
    input  logic                       sum_i,
    input  logic                       mxr_i,
    input  logic                       lu_hit_i,
    input  logic [mmu_pkg::PPNW-1:0]   lu_ppn_i,
    input  mmu_pkg::pte_flags_t        lu_flags_i,
    input  logic                       ptw_error_i,
    output logic                       lsu_dtlb_hit_o,
    output logic                       lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0]   lsu_paddr_o,
    output logic                       lsu_exc_valid_o,
    output mmu_pkg::exc_cause_e        lsu_exc_cause_o,
    output logic [mmu_pkg::VLEN-1:0]   lsu_exc_tval_o
);
    import mmu_pkg::*;

    // registered request and tlb answer
    logic            req_q;
    logic            en_q;
    logic            hit_q;
    logic [VLEN-1:0] vaddr_q;
    logic            is_store_q;
    logic [PPNW-1:0] ppn_q;
    pte_flags_t      flags_q;

    logic            priv_err;
    logic            perm_err;
    logic            hit_valid;

    // untranslated accesses are always ready
    assign lsu_dtlb_hit_o = en_translation_i ? lu_hit_i : 1'b1;

    // ----------------------------------------------------------------------
    // request register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            en_q  <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            en_q  <= en_translation_i;
            hit_q <= lu_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        ppn_q      <= lu_ppn_i;
        flags_q    <= lu_flags_i;
    end

    // ----------------------------------------------------------------------
    // permission checks
    // ----------------------------------------------------------------------
    // S mode touches U pages only with SUM, U mode only U pages
    assign priv_err = ((priv_lvl_i == PRIV_S) && flags_q.u && !sum_i) ||
                      ((priv_lvl_i == PRIV_U) && !flags_q.u);

    // stores need W and an already set D bit
    // loads need R, or X when MXR is set
    assign perm_err = is_store_q ? (!flags_q.w || !flags_q.d)
                                 : !(flags_q.r || (flags_q.x && mxr_i));

    assign hit_valid = req_q && en_q && hit_q;

    // ----------------------------------------------------------------------
    // result
    // ----------------------------------------------------------------------
    // ppn already carries vaddr[21:12] for a superpage hit
    assign lsu_paddr_o = en_q ? {ppn_q, vaddr_q[PAGE_OFFW-1:0]} : vaddr_q;

    // a walk error completes the held request with a fault
    assign lsu_valid_o     = (req_q && (!en_q || hit_q)) || ptw_error_i;
    assign lsu_exc_valid_o = ptw_error_i || (hit_valid && (priv_err || perm_err));
    assign lsu_exc_cause_o = is_store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
    assign lsu_exc_tval_o  = vaddr_q;

    // walker errors only arrive while the missing request is still held,
    // so every valid result belongs to a registered request
    assert property (@(posedge clk_i) disable iff (!rst_ni) lsu_valid_o |-> req_q);

endmodule

`default_nettype wire

//--- rtl/mmu_pkg.sv
// shared widths, page table entry fields and enums, imported by every MMU module
`default_nettype none

package mmu_pkg;

    // ----------------------------------------------------------------------
    // address and page geometry (Sv32)
    // ----------------------------------------------------------------------
    localparam int unsigned VLEN      = 32;
    localparam int unsigned PLEN      = 32;
    localparam int unsigned PPNW      = 20;
    // one level of the virtual page number
    localparam int unsigned VPNW      = 10;
    localparam int unsigned PAGE_OFFW = 12;

    localparam int unsigned TLB_ENTRIES_DEF = 4;

    // ----------------------------------------------------------------------
    // page table entry bit positions
    // ----------------------------------------------------------------------
    localparam int unsigned PTE_V       = 0;
    localparam int unsigned PTE_R       = 1;
    localparam int unsigned PTE_W       = 2;
    localparam int unsigned PTE_X       = 3;
    localparam int unsigned PTE_U       = 4;
    localparam int unsigned PTE_A       = 6;
    localparam int unsigned PTE_D       = 7;
    // ppn occupies bits 29:10
    localparam int unsigned PTE_PPN_LSB = 10;

    // permission flags kept per tlb entry, G and RSW are not stored
    typedef struct packed {
        logic d;
        logic a;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    typedef enum logic [0:0] {
        PRIV_U = 1'b0,
        PRIV_S = 1'b1
    } priv_lvl_e;

    // mcause codes of the two page faults the data side can raise
    typedef enum logic [4:0] {
        LOAD_PAGE_FAULT  = 5'd13,
        STORE_PAGE_FAULT = 5'd15
    } exc_cause_e;

    typedef enum logic [2:0] {
        PTW_IDLE,
        PTW_REQ_L1,
        PTW_WAIT_L1,
        PTW_REQ_L0,
        PTW_WAIT_L0,
        PTW_FAULT
    } ptw_state_e;

endpackage

`default_nettype wire

//--- rtl/mmu_ptw.sv
// Sv32 page table walker, started by a data TLB miss and finished by a refill or a fault
`timescale 1ns/1ps
`default_nettype none

module mmu_ptw (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     en_translation_i,
    input  logic                     lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0] lsu_vaddr_i,
    input  logic                     lu_hit_i,
    input  logic [mmu_pkg::PPNW-1:0] satp_ppn_i,
    mmu_tlb_upd_if.walker            upd,
    output logic                     ptw_error_o,
    output logic                     dtlb_miss_o,
    output logic                     mem_req_o,
    output logic [mmu_pkg::PLEN-1:0] mem_addr_o,
    input  logic                     mem_rvalid_i,
    input  logic [31:0]              mem_rdata_i
);
    import mmu_pkg::*;

    ptw_state_e      state_q, state_d;
    // address of the access that missed, held for the whole walk
    logic [VLEN-1:0] vaddr_q;
    logic [PLEN-1:0] addr_q, addr_d;

    logic            start;
    logic            level1;
    logic [PPNW-1:0] pte_ppn;
    pte_flags_t      pte;
    logic            pte_bad;
    logic            pte_leaf;
    logic            leaf_bad;

    // ----------------------------------------------------------------------
    // pte decode
    // ----------------------------------------------------------------------
    assign pte_ppn = mem_rdata_i[PTE_PPN_LSB +: PPNW];
    assign pte = '{
        d: mem_rdata_i[PTE_D],
        a: mem_rdata_i[PTE_A],
        u: mem_rdata_i[PTE_U],
        x: mem_rdata_i[PTE_X],
        w: mem_rdata_i[PTE_W],
        r: mem_rdata_i[PTE_R],
        v: mem_rdata_i[PTE_V]
    };

    assign level1   = (state_q == PTW_REQ_L1) || (state_q == PTW_WAIT_L1);
    // invalid, or the reserved W without R encoding
    assign pte_bad  = !pte.v || (pte.w && !pte.r);
    assign pte_leaf = pte.r || pte.x;
    // no hardware A/D update, a clear A bit is a fault
    // superpage leaf must be 4 MiB aligned
    assign leaf_bad = !pte.a || (level1 && (pte_ppn[VPNW-1:0] != '0));

    // a translated request that misses while idle kicks off a walk
    assign start       = (state_q == PTW_IDLE) && en_translation_i && lsu_req_i && !lu_hit_i;
    assign dtlb_miss_o = start;

    // read is held until the data comes back
    assign mem_req_o   = (state_q != PTW_IDLE) && (state_q != PTW_FAULT);
    assign mem_addr_o  = addr_q;
    assign ptw_error_o = (state_q == PTW_FAULT);

    // refill payload, qualified by upd.valid
    assign upd.vpn      = vaddr_q[VLEN-1:PAGE_OFFW];
    assign upd.ppn      = pte_ppn;
    assign upd.is_super = level1;
    assign upd.flags    = pte;

    // ----------------------------------------------------------------------
    // walker FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_d   = state_q;
        addr_d    = addr_q;
        upd.valid = 1'b0;
        case (state_q)
            PTW_IDLE: begin
                if (start) begin
                    state_d = PTW_REQ_L1;
                    // root table plus 4 * vpn[1]
                    addr_d  = {satp_ppn_i, lsu_vaddr_i[VLEN-1 -: VPNW], 2'b00};
                end
            end
            PTW_FAULT: begin
                state_d = PTW_IDLE;
            end
            default: begin
                // data may already arrive in a REQ state
                if (mem_rvalid_i) begin
                    if (pte_bad) begin
                        state_d = PTW_FAULT;
                    end else if (pte_leaf) begin
                        if (leaf_bad) begin
                            state_d = PTW_FAULT;
                        end else begin
                            upd.valid = 1'b1;
                            state_d   = PTW_IDLE;
                        end
                    end else if (level1) begin
                        // pointer to the second level, plus 4 * vpn[0]
                        state_d = PTW_REQ_L0;
                        addr_d  = {pte_ppn, vaddr_q[PAGE_OFFW +: VPNW], 2'b00};
                    end else begin
                        // Sv32 has no third level
                        state_d = PTW_FAULT;
                    end
                end else if (state_q == PTW_REQ_L1) begin
                    state_d = PTW_WAIT_L1;
                end else if (state_q == PTW_REQ_L0) begin
                    state_d = PTW_WAIT_L0;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= PTW_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
        if (start) begin
            vaddr_q <= lsu_vaddr_i;
        end
    end

    // memory sees a stable read until it answers
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_rvalid_i |=> mem_req_o && $stable(mem_addr_o));

endmodule

`default_nettype wire

//--- rtl/mmu_tlb_upd_if.sv
// refill bundle from the page table walker into the data TLB, one pulse per refill
`timescale 1ns/1ps
`default_nettype none

interface mmu_tlb_upd_if;
    import mmu_pkg::*;

    // one-cycle write strobe
    logic                      valid;
    // full virtual page number of the walked address
    logic [VLEN-PAGE_OFFW-1:0] vpn;
    // leaf ppn exactly as read from the pte
    logic [PPNW-1:0]           ppn;
    // leaf found at the first level, 4 MiB page
    logic                      is_super;
    pte_flags_t                flags;

    modport walker (
        output valid, vpn, ppn, is_super, flags
    );

    modport tlb (
        input valid, vpn, ppn, is_super, flags
    );

endinterface

`default_nettype wire

//--- rtl/mmu_top.sv
// data-side Sv32 MMU top level, wires the TLB, walker and load/store stage to plain ports
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       en_translation_i,
    input  logic                       flush_tlb_i,
    input  logic                       lsu_req_i,
    input  logic [mmu_pkg::VLEN-1:0]   lsu_vaddr_i,
    input  logic                       lsu_is_store_i,
    input  mmu_pkg::priv_lvl_e         priv_lvl_i,
    input  logic                       sum_i,
    input  logic                       mxr_i,
    input  logic [mmu_pkg::PPNW-1:0]   satp_ppn_i,
    output logic                       lsu_dtlb_hit_o,
    output logic                       lsu_valid_o,
    output logic [mmu_pkg::PLEN-1:0]   lsu_paddr_o,
    output logic                       lsu_exc_valid_o,
    output mmu_pkg::exc_cause_e        lsu_exc_cause_o,
    output logic [mmu_pkg::VLEN-1:0]   lsu_exc_tval_o,
    output logic                       dtlb_miss_o,
    output logic                       mem_req_o,
    output logic [mmu_pkg::PLEN-1:0]   mem_addr_o,
    input  logic                       mem_rvalid_i,
    input  logic [31:0]                mem_rdata_i
);
    import mmu_pkg::*;

    // tlb lookup result, shared by walker and load/store stage
    logic            lu_hit;
    logic [PPNW-1:0] lu_ppn;
    pte_flags_t      lu_flags;
    logic            ptw_error;

    mmu_tlb_upd_if upd_if ();

    mmu_dtlb #(
        .NR_ENTRIES    ( TLB_ENTRIES_DEF )
    ) i_dtlb (
        .clk_i         ( clk_i           ),
        .rst_ni        ( rst_ni          ),
        .flush_i       ( flush_tlb_i     ),
        .upd           ( upd_if.tlb      ),
        .lu_vaddr_i    ( lsu_vaddr_i     ),
        .lu_hit_o      ( lu_hit          ),
        .lu_ppn_o      ( lu_ppn          ),
        // page size is already folded into lu_ppn
        .lu_is_super_o (                 ),
        .lu_flags_o    ( lu_flags        )
    );

    mmu_ptw i_ptw (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .en_translation_i ( en_translation_i ),
        .lsu_req_i        ( lsu_req_i        ),
        .lsu_vaddr_i      ( lsu_vaddr_i      ),
        .lu_hit_i         ( lu_hit           ),
        .satp_ppn_i       ( satp_ppn_i       ),
        .upd              ( upd_if.walker    ),
        .ptw_error_o      ( ptw_error        ),
        .dtlb_miss_o      ( dtlb_miss_o      ),
        .mem_req_o        ( mem_req_o        ),
        .mem_addr_o       ( mem_addr_o       ),
        .mem_rvalid_i     ( mem_rvalid_i     ),
        .mem_rdata_i      ( mem_rdata_i      )
    );

    mmu_lsu_stage i_lsu_stage (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .en_translation_i ( en_translation_i ),
        .lsu_req_i        ( lsu_req_i        ),
        .lsu_vaddr_i      ( lsu_vaddr_i      ),
        .lsu_is_store_i   ( lsu_is_store_i   ),
        .priv_lvl_i       ( priv_lvl_i       ),
        .sum_i            ( sum_i            ),
        .mxr_i            ( mxr_i            ),
        .lu_hit_i         ( lu_hit           ),
        .lu_ppn_i         ( lu_ppn           ),
        .lu_flags_i       ( lu_flags         ),
        .ptw_error_i      ( ptw_error        ),
        .lsu_dtlb_hit_o   ( lsu_dtlb_hit_o   ),
        .lsu_valid_o      ( lsu_valid_o      ),
        .lsu_paddr_o      ( lsu_paddr_o      ),
        .lsu_exc_valid_o  ( lsu_exc_valid_o  ),
        .lsu_exc_cause_o  ( lsu_exc_cause_o  ),
        .lsu_exc_tval_o   ( lsu_exc_tval_o   )
    );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// clock and reset source for the MMU testbench, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // release just after an edge, away from the flops sampling it
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/tb_mmu.sv
// simulation top that checks the data MMU against a reference walk of page tables in a memory model
`timescale 1ns/1ps
`default_nettype none

module tb_mmu;
    import mmu_pkg::*;

    localparam int DRIVE_DLY  = 5;
    // limit for about 30 requests that each take well under 100 cycles
    localparam int MAX_CYCLES = 4000;
    localparam int MEM_WORDS  = 4096;
    localparam logic [7:0] FV = 8'(1 << PTE_V);
    localparam logic [7:0] FR = 8'(1 << PTE_R);
    localparam logic [7:0] FW = 8'(1 << PTE_W);
    localparam logic [7:0] FX = 8'(1 << PTE_X);
    localparam logic [7:0] FU = 8'(1 << PTE_U);
    localparam logic [7:0] FA = 8'(1 << PTE_A);
    localparam logic [7:0] FD = 8'(1 << PTE_D);

    logic clk_i, rst_ni;
    logic en_translation_i, flush_tlb_i, lsu_req_i, lsu_is_store_i;
    logic sum_i, mxr_i, mem_rvalid_i;
    logic [31:0] lsu_vaddr_i, mem_rdata_i;
    logic [19:0] satp_ppn_i;
    priv_lvl_e priv_lvl_i;
    logic lsu_dtlb_hit_o, lsu_valid_o, lsu_exc_valid_o, dtlb_miss_o, mem_req_o;
    logic [31:0] lsu_paddr_o, lsu_exc_tval_o, mem_addr_o;
    exc_cause_e lsu_exc_cause_o;

    // page table memory of 16 KiB from address 0
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] lfsr_q = 32'hd5c0_f444;
    // expected result of the request in flight
    logic        exp_exc, exp_walk_ok;
    exc_cause_e  exp_cause;
    logic [31:0] exp_value;
    int          cycle_cnt;

    tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(5)) clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

    mmu_top mmu_top_i (.*);

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    // Galois LFSR stepped once per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] make_pte(input logic [19:0] ppn, input logic [7:0] fl);
        return {2'b00, ppn, 2'b00, fl};
    endfunction

    function automatic logic [31:0] make_va(input int vpn1, input int vpn0, input int off);
        return {vpn1[9:0], vpn0[9:0], off[11:0]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return (addr[31:14] != '0) ? 32'h0 : mem[addr[13:2]];
    endfunction

    task automatic set_pte(input logic [19:0] table_ppn, input int idx, input logic [31:0] pte);
        logic [31:0] addr;
        addr = {table_ppn, idx[9:0], 2'b00};
        mem[addr[13:2]] = pte;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // ----------------------------------------------------------------------
    // reference Sv32 translation with the permission rules
    // ----------------------------------------------------------------------
    function automatic void ref_translate(
        input  logic [31:0] va,
        input  logic        st,
        input  logic        en,
        input  priv_lvl_e   priv,
        input  logic        sum,
        input  logic        mxr,
        output logic        exc,
        output exc_cause_e  cause,
        output logic [31:0] value,
        output logic        walk_ok
    );
        logic [31:0] pte;
        logic        is_super;
        cause    = st ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        walk_ok  = 1'b1;
        is_super = 1'b1;
        if (!en) begin
            exc   = 1'b0;
            value = va;
            return;
        end
        pte = read_word({satp_ppn_i, va[31:22], 2'b00});
        if (!pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R])) begin
            walk_ok = 1'b0;
        end else if (!pte[PTE_R] && !pte[PTE_X]) begin
            // pointer to the second level
            is_super = 1'b0;
            pte      = read_word({pte[29:10], va[21:12], 2'b00});
            if (!pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R])) walk_ok = 1'b0;
            if (!pte[PTE_R] && !pte[PTE_X]) walk_ok = 1'b0;
        end
        if (!pte[PTE_A] || (is_super && pte[19:10] != '0)) walk_ok = 1'b0;
        exc = !walk_ok;
        if (priv == PRIV_S ? (pte[PTE_U] && !sum) : !pte[PTE_U]) exc = 1'b1;
        if (st ? !(pte[PTE_W] && pte[PTE_D]) : !(pte[PTE_R] || (pte[PTE_X] && mxr))) exc = 1'b1;
        if (exc) value = va;
        else if (is_super) value = {pte[29:20], va[21:0]};
        else value = {pte[29:10], va[11:0]};
    endfunction

    // ----------------------------------------------------------------------
    // memory model that answers each read after 1 to 4 cycles
    // ----------------------------------------------------------------------
    initial begin : memory_model
        int          lat;
        logic [31:0] addr;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(negedge clk_i);
            if (rst_ni && mem_req_o) begin
                addr = mem_addr_o;
                lat  = 1 + lfsr_q[0];
                lfsr_q = lfsr_next(lfsr_q);
                lat  = lat + 2 * lfsr_q[0];
                lfsr_q = lfsr_next(lfsr_q);
                if (addr[31:14] != '0) begin
                    $display("ERROR: walker read address %h outside the page tables", addr);
                    $display("Simulation FAILED");
                    $fatal(1, "bad walker read");
                end
                repeat (lat) @(posedge clk_i);
                #DRIVE_DLY;
                mem_rvalid_i = 1'b1;
                mem_rdata_i  = mem[addr[13:2]];
                @(posedge clk_i);
                #DRIVE_DLY;
                mem_rvalid_i = 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // result compare for every answer of a held request
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni && lsu_valid_o) begin
            check_value("lsu_exc_valid_o", lsu_exc_valid_o, exp_exc);
            if (exp_exc) begin
                check_value("lsu_exc_cause_o", 32'(lsu_exc_cause_o), 32'(exp_cause));
                check_value("lsu_exc_tval_o", lsu_exc_tval_o, exp_value);
            end else begin
                check_value("lsu_paddr_o", lsu_paddr_o, exp_value);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
    end

    initial begin : watchdog
        wait (cycle_cnt >= MAX_CYCLES);
        $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    // one request held until lsu_valid_o, then its miss count and latency are checked
    task automatic access(input logic [31:0] va, input logic st, input int exp_miss);
        int cyc;
        int misses;
        int hit_cyc;
        @(posedge clk_i);
        #DRIVE_DLY;
        ref_translate(va, st, en_translation_i, priv_lvl_i, sum_i, mxr_i,
                      exp_exc, exp_cause, exp_value, exp_walk_ok);
        lsu_req_i      = 1'b1;
        lsu_vaddr_i    = va;
        lsu_is_store_i = st;
        cyc            = 0;
        misses         = 0;
        hit_cyc        = -1;
        forever begin
            @(negedge clk_i);
            if (lsu_valid_o) begin
                break;
            end
            if (dtlb_miss_o) misses++;
            if (lsu_dtlb_hit_o) hit_cyc = cyc;
            cyc++;
        end
        check_value("dtlb_miss_o pulses", misses, exp_miss);
        if (exp_walk_ok) begin
            check_value("cycles from lsu_dtlb_hit_o to lsu_valid_o", cyc - hit_cyc, 1);
        end else begin
            check_value("lsu_dtlb_hit_o during faulting walk", hit_cyc, -1);
        end
        if (exp_miss == 0) check_value("lsu_valid_o latency", cyc, 1);
        @(posedge clk_i);
        #DRIVE_DLY;
        lsu_req_i = 1'b0;
        // registered copy of the request still answers once
        repeat (2) @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        en_translation_i = 1'b0;
        flush_tlb_i      = 1'b0;
        lsu_req_i        = 1'b0;
        lsu_vaddr_i      = '0;
        lsu_is_store_i   = 1'b0;
        priv_lvl_i       = PRIV_S;
        sum_i            = 1'b0;
        mxr_i            = 1'b0;
        satp_ppn_i       = 20'h1;
        cycle_cnt        = 0;
        // unused words are invalid entries that still depend on the address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {4'ha, i[11:0], i[11:0], 4'h0};
        end
        // root table at ppn 1 and second level at ppn 2
        set_pte(20'h1, 1, make_pte(20'h00002, FV));
        set_pte(20'h1, 2, make_pte(20'h0ac00, FV | FR | FW | FA | FD));
        set_pte(20'h1, 3, make_pte(20'h0ac05, FV | FR | FW | FA | FD));
        set_pte(20'h1, 4, make_pte(20'h00003, FR));
        set_pte(20'h1, 5, make_pte(20'h0c800, FV | FR | FW | FU | FA | FD));
        set_pte(20'h2, 'h10, make_pte(20'h12345, FV | FR | FW | FA | FD));
        set_pte(20'h2, 'h11, make_pte(20'h23456, FV | FR | FW | FU | FA | FD));
        set_pte(20'h2, 'h12, make_pte(20'h34567, FV | FR | FA));
        set_pte(20'h2, 'h13, make_pte(20'h45678, FV | FR | FW | FA));
        set_pte(20'h2, 'h14, make_pte(20'h56789, FV | FX | FA));
        set_pte(20'h2, 'h15, make_pte(20'h6789a, FR | FW | FA | FD));
        set_pte(20'h2, 'h16, make_pte(20'h789ab, FV | FR | FW | FD));
        set_pte(20'h2, 'h17, make_pte(20'h00003, FV));
        set_pte(20'h2, 'h18, make_pte(20'h9abcd, FV | FW | FA | FD));
        wait (rst_ni);

        // bare mode
        access(32'h0001_0abc, 1'b0, 0);
        access(32'h8000_0004, 1'b1, 0);
        en_translation_i = 1'b1;
        // 4 KiB page that misses and then hits
        access(make_va(1, 'h10, 'h123), 1'b0, 1);
        access(make_va(1, 'h10, 'h456), 1'b1, 0);
        // superpage
        access(make_va(2, 'h155, 'h678), 1'b0, 1);
        access(make_va(2, 'h3ff, 'hffc), 1'b1, 0);
        // privilege and permission faults
        access(make_va(1, 'h11, 'h010), 1'b0, 1);
        sum_i = 1'b1;
        access(make_va(1, 'h11, 'h014), 1'b0, 0);
        sum_i      = 1'b0;
        priv_lvl_i = PRIV_U;
        access(make_va(1, 'h10, 'h020), 1'b0, 0);
        access(make_va(1, 'h11, 'h024), 1'b1, 0);
        priv_lvl_i = PRIV_S;
        access(make_va(1, 'h12, 'h030), 1'b1, 1);
        access(make_va(1, 'h12, 'h034), 1'b0, 0);
        access(make_va(1, 'h13, 'h040), 1'b1, 1);
        access(make_va(1, 'h13, 'h044), 1'b0, 0);
        access(make_va(1, 'h14, 'h050), 1'b0, 1);
        mxr_i = 1'b1;
        access(make_va(1, 'h14, 'h054), 1'b0, 0);
        mxr_i = 1'b0;
        // walk faults leave nothing in the TLB
        access(make_va(1, 'h15, 'h060), 1'b0, 1);
        access(make_va(1, 'h15, 'h064), 1'b1, 1);
        access(make_va(4, 'h001, 'h070), 1'b0, 1);
        access(make_va(3, 'h002, 'h080), 1'b1, 1);
        access(make_va(1, 'h16, 'h090), 1'b0, 1);
        access(make_va(1, 'h17, 'h0a0), 1'b0, 1);
        access(make_va(1, 'h18, 'h0b0), 1'b1, 1);
        // user superpage
        priv_lvl_i = PRIV_U;
        access(make_va(5, 'h2aa, 'h0c0), 1'b1, 1);
        priv_lvl_i = PRIV_S;
        // flush drops a hitting entry
        access(make_va(1, 'h12, 'h0d0), 1'b0, 0);
        flush_tlb_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY;
        flush_tlb_i = 1'b0;
        access(make_va(1, 'h12, 'h0d4), 1'b0, 1);
        access(make_va(1, 'h12, 'h0d8), 1'b0, 0);
        en_translation_i = 1'b0;
        access(32'hdead_beec, 1'b1, 0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
